//--- rtl/upAlu.sv
`include "up_consts.svh"

module upAlu (
	input  upPkg::aluOpT op,
	input  logic [`UP_DATA_W-1:0] acc,
	input  logic [`UP_DATA_W-1:0] operand,
	output logic [`UP_DATA_W-1:0] result,
	output logic zero
);

	// all arithmetic wraps at the word width.
	always_comb begin
		case (op)
			upPkg::aluPass: begin
				result = operand;
			end
			upPkg::aluAdd: begin
				result = acc + operand;
			end
			upPkg::aluSub: begin
				result = acc - operand;
			end
			upPkg::aluAnd: begin
				result = acc & operand;
			end
			upPkg::aluXor: begin
				result = acc ^ operand;
			end
			default: begin
				result = operand;
			end
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- rtl/upControl.sv
`include "up_consts.svh"

module upControl (
	input  logic clk,
	input  logic nRst,
	input  logic run,
	input  logic [`UP_DATA_W-1:0] rdata,
	input  upPkg::decodedT dec,
	input  logic [`UP_DATA_W-1:0] aluResult,
	input  logic aluZero,
	output logic [`UP_DATA_W-1:0] memAddr,
	output logic [`UP_DATA_W-1:0] wdata,
	output logic we,
	output logic halted,
	output logic [`UP_DATA_W-1:0] acc,
	output logic [`UP_DATA_W-1:0] opcode
);

	typedef enum logic [1:0] {
		stFetchOp = 2'd0,
		stFetchAddr = 2'd1,
		stExec = 2'd2
	} stateT;

	stateT state;
	logic [`UP_DATA_W-1:0] pc;
	logic [`UP_DATA_W-1:0] operandAddr;
	logic accZero;
	logic advance;
	logic execute;
	logic takeJump;

	assign advance = run && !halted;
	assign execute = (state == stExec);

	// jz looks at the accumulator as it stands before this instruction.
	assign takeJump = dec.isJump && (!dec.jumpIfZero || accZero);

	assign memAddr = execute ? operandAddr : pc;
	assign wdata = acc;
	assign we = run && execute && dec.writesMem;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stFetchOp;
			pc <= '0;
			halted <= 1'b0;
		end else if (!run) begin
			state <= stFetchOp; // parked until run rises.
			pc <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			case (state)
				stFetchOp: begin
					state <= stFetchAddr;
					pc <= pc + 1'b1;
				end
				stFetchAddr: begin
					state <= stExec;
					pc <= pc + 1'b1;
				end
				stExec: begin
					state <= stFetchOp;
					if (takeJump) begin
						pc <= operandAddr;
					end
					if (dec.isHalt) begin
						halted <= 1'b1;
					end
				end
				default: begin
					state <= stFetchOp;
				end
			endcase
		end
	end

	// instruction register, a no-op after reset.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			opcode <= '0;
		end else if (advance && state == stFetchOp) begin
			opcode <= rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && state == stFetchAddr) begin
			operandAddr <= rdata;
		end
	end

	// zero flag tracks the accumulator.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			acc <= '0;
			accZero <= 1'b1;
		end else if (advance && execute && dec.writesAcc) begin
			acc <= aluResult;
			accZero <= aluZero;
		end
	end

endmodule

//--- rtl/upDecoder.sv
`include "up_consts.svh"

module upDecoder (
	input  logic [`UP_DATA_W-1:0] opcode,
	output upPkg::decodedT dec
);

	always_comb begin
		dec = '0;
		dec.aluOp = upPkg::aluPass;
		case (opcode)
			upPkg::opLda: begin
				dec.aluOp = upPkg::aluPass;
				dec.writesAcc = 1'b1;
			end
			upPkg::opSta: begin
				dec.writesMem = 1'b1;
			end
			upPkg::opAdd: begin
				dec.aluOp = upPkg::aluAdd;
				dec.writesAcc = 1'b1;
			end
			upPkg::opSub: begin
				dec.aluOp = upPkg::aluSub;
				dec.writesAcc = 1'b1;
			end
			upPkg::opAnd: begin
				dec.aluOp = upPkg::aluAnd;
				dec.writesAcc = 1'b1;
			end
			upPkg::opXor: begin
				dec.aluOp = upPkg::aluXor;
				dec.writesAcc = 1'b1;
			end
			upPkg::opJmp: begin
				dec.isJump = 1'b1;
			end
			upPkg::opJz: begin
				dec.isJump = 1'b1;
				dec.jumpIfZero = 1'b1;
			end
			upPkg::opHlt: begin
				dec.isHalt = 1'b1;
			end
			default: begin
				dec = '0; // no-op.
			end
		endcase
	end

endmodule

//--- rtl/upMemory.sv
`include "up_consts.svh"

module upMemory (
	input  logic clk,
	input  logic nRst,
	input  logic we,
	input  logic [`UP_DATA_W-1:0] addr,
	input  logic [`UP_DATA_W-1:0] wdata,
	output logic [`UP_DATA_W-1:0] rdata,
	output logic [`UP_DATA_W-1:0] probe
);

	logic [`UP_DATA_W-1:0] mem [`UP_MEM_DEPTH];

	// boot program: acc = mem[64] + mem[65], store at 128, halt.
	function automatic logic [`UP_DATA_W-1:0] bootByte(input int unsigned idx);
		case (idx)
			0: return `UP_OP_LDA;
			1: return 8'd64;
			2: return `UP_OP_ADD;
			3: return 8'd65;
			4: return `UP_OP_STA;
			5: return 8'd128;
			6: return `UP_OP_HLT;
			7: return 8'd0;
			64: return 8'h5a; // first addend.
			65: return 8'hc3; // second addend, sum wraps.
			default: return '0;
		endcase
	endfunction

	assign rdata = mem[addr];
	assign probe = mem[`UP_PROBE_ADDR];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `UP_MEM_DEPTH; i++) begin
				if (i < `UP_BOOT_LEN) begin
					mem[i] <= bootByte(i);
				end else begin
					mem[i] <= '0;
				end
			end
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

//--- rtl/upPkg.sv
`include "up_consts.svh"

package upPkg;

	// any byte outside this set runs as a no-op.
	typedef enum logic [`UP_DATA_W-1:0] {
		opLda = `UP_OP_LDA,
		opSta = `UP_OP_STA,
		opAdd = `UP_OP_ADD,
		opSub = `UP_OP_SUB,
		opAnd = `UP_OP_AND,
		opXor = `UP_OP_XOR,
		opJmp = `UP_OP_JMP,
		opJz = `UP_OP_JZ,
		opHlt = `UP_OP_HLT
	} opcodeT;

	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluXor = 3'd4
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic writesAcc; // acc <= alu result.
		logic writesMem; // mem[operand] <= acc.
		logic isJump;
		logic jumpIfZero; // only with isJump.
		logic isHalt;
	} decodedT;

	typedef struct packed {
		logic en;
		logic [`UP_DATA_W-1:0] addr;
		logic [`UP_DATA_W-1:0] data;
	} hostWriteT;

endpackage

//--- rtl/upTop.sv
`include "up_consts.svh"

module upTop (
	input  logic clk,
	input  logic nRst,
	input  logic run,
	input  upPkg::hostWriteT host,
	output logic [`UP_DATA_W-1:0] probe,
	output logic [`UP_DATA_W-1:0] acc,
	output logic halted
);

	logic coreWe;
	logic [`UP_DATA_W-1:0] coreAddr;
	logic [`UP_DATA_W-1:0] coreWdata;
	logic memWe;
	logic [`UP_DATA_W-1:0] memAddr;
	logic [`UP_DATA_W-1:0] memWdata;
	logic [`UP_DATA_W-1:0] rdata;
	logic [`UP_DATA_W-1:0] opcode;
	logic [`UP_DATA_W-1:0] aluResult;
	logic aluZero;
	upPkg::decodedT dec;

	// host owns the memory while the core is stopped.
	always_comb begin
		if (run) begin
			memWe = coreWe;
			memAddr = coreAddr;
			memWdata = coreWdata;
		end else begin
			memWe = host.en;
			memAddr = host.addr;
			memWdata = host.data;
		end
	end

	upMemory upMemory_i (
		.clk(clk),
		.nRst(nRst),
		.we(memWe),
		.addr(memAddr),
		.wdata(memWdata),
		.rdata(rdata),
		.probe(probe)
	);

	upDecoder upDecoder_i (
		.opcode(opcode),
		.dec(dec)
	);

	upAlu upAlu_i (
		.op(dec.aluOp),
		.acc(acc),
		.operand(rdata),
		.result(aluResult),
		.zero(aluZero)
	);

	upControl upControl_i (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.rdata(rdata),
		.dec(dec),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.memAddr(coreAddr),
		.wdata(coreWdata),
		.we(coreWe),
		.halted(halted),
		.acc(acc),
		.opcode(opcode)
	);

endmodule

//--- rtl/up_consts.svh
`ifndef UP_CONSTS_SVH
`define UP_CONSTS_SVH

// one word is both a data byte and an address.
`define UP_DATA_W 8

`define UP_MEM_DEPTH 256

// result byte brought out as the probe.
`define UP_PROBE_ADDR 128

// bytes 0 .. UP_BOOT_LEN-1 hold the boot image.
`define UP_BOOT_LEN 66

// opcode bytes.
`define UP_OP_LDA 8'h01
`define UP_OP_STA 8'h02
`define UP_OP_ADD 8'h03
`define UP_OP_SUB 8'h04
`define UP_OP_AND 8'h05
`define UP_OP_XOR 8'h06
`define UP_OP_JMP 8'h07
`define UP_OP_JZ 8'h08
`define UP_OP_HLT 8'h09

`endif

//--- run.sh
#!/bin/sh
# builds and runs upTb with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module upTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "run.sh: compile failed"
	exit 1
fi

# assertion errors must not stop the run before the closing report.
out=$(./obj_dir/VupTb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "run.sh: simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Finished with no errors$"; then
	exit 0
fi
echo "run.sh: pass message not found"
exit 1

//--- sim.f
+incdir+rtl
rtl/upPkg.sv
rtl/upMemory.sv
rtl/upDecoder.sv
rtl/upAlu.sv
rtl/upControl.sv
rtl/upTop.sv
tests/upTop_props.sv
tests/upTb.sv

//--- tests/upTb.sv
`include "up_consts.svh"

module upTb;

	localparam int BIN_PROGS = 8; // programs per binary-op test.
	localparam int MAX_COUNT = 7;
	// boot, two binary-op tests, the longest countdown, the no-op program.
	localparam int INSTR_TOTAL = 4 + 2 * BIN_PROGS * 4 + (8 * MAX_COUNT + 5) + 7;
	localparam int CYCLE_LIMIT = INSTR_TOTAL * 3 + 500; // reset and host writes.
	localparam logic [7:0] BOOT_A = 8'h5a; // data bytes of the boot image.
	localparam logic [7:0] BOOT_B = 8'hc3;

	logic clk;
	logic nRst;
	logic run;
	upPkg::hostWriteT host;
	logic [`UP_DATA_W-1:0] probe;
	logic [`UP_DATA_W-1:0] acc;
	logic halted;

	logic [31:0] rngState = 32'hb3e06319;
	int cycleCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testStartErrors = 0;

	upTop upTop_i (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.host(host),
		.probe(probe),
		.acc(acc),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
		$display("Finished with errors");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic randByte(output logic [7:0] b);
		rngState = xorshift32(rngState);
		b = rngState[15:8];
	endtask

	function automatic int totalErrors();
		return errorCount + int'(upTop_i.upTopProps_i.failCount);
	endfunction

	// one host write per cycle, entered and left 1 unit after an edge.
	task automatic poke(input logic [7:0] addr, input logic [7:0] data);
		host.en = 1'b1;
		host.addr = addr;
		host.data = data;
		@(posedge clk);
		#1;
		host.en = 1'b0;
	endtask

	task automatic pokeInstr(input logic [7:0] addr, input logic [7:0] op, input logic [7:0] arg);
		poke(addr, op);
		poke(addr + 8'd1, arg);
	endtask

	task automatic runToHalt();
		run = 1'b1;
		while (!halted) begin
			@(posedge clk);
			#1;
		end
		run = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] want);
		assert (got == want) else begin
			errorCount++;
			$display("[ERROR] %s: expected %h, got %h", name, want, got);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (totalErrors() == testStartErrors) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			failedTests++;
			$display("test %0d %s: FAILED", testCount, name);
		end
		testStartErrors = totalErrors();
	endtask

	// lda 64, op 65, sta 128, hlt.
	task automatic runBinary(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b,
			input logic [7:0] want);
		poke(8'd64, a);
		poke(8'd65, b);
		poke(8'(`UP_PROBE_ADDR), ~want); // stale probe never matches.
		pokeInstr(8'd0, `UP_OP_LDA, 8'd64);
		pokeInstr(8'd2, op, 8'd65);
		pokeInstr(8'd4, `UP_OP_STA, 8'(`UP_PROBE_ADDR));
		pokeInstr(8'd6, `UP_OP_HLT, 8'd0);
		runToHalt();
		checkByte("probe", probe, want);
	endtask

	initial begin
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] n;
		run = 1'b0;
		host = '0;
		nRst = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		nRst = 1'b1;

		runToHalt();
		checkByte("probe", probe, 8'((int'(BOOT_A) + int'(BOOT_B)) % 256));
		endTest("boot program");

		for (int i = 0; i < BIN_PROGS; i++) begin
			randByte(a);
			randByte(b);
			if (i % 2 == 0) begin
				runBinary(`UP_OP_ADD, a, b, 8'((int'(a) + int'(b)) % 256));
			end else begin
				runBinary(`UP_OP_SUB, a, b, 8'((256 + int'(a) - int'(b)) % 256));
			end
		end
		endTest("add and subtract");

		for (int i = 0; i < BIN_PROGS; i++) begin
			randByte(a);
			randByte(b);
			if (i % 2 == 0) begin
				runBinary(`UP_OP_AND, a, b, a & b);
			end else begin
				runBinary(`UP_OP_XOR, a, b, a ^ b);
			end
		end
		endTest("and and xor");

		// counter at 100, step at 101, iterations at 102.
		randByte(n);
		n = 8'(int'(n) % MAX_COUNT + 1);
		poke(8'd100, n);
		poke(8'd101, 8'd1);
		poke(8'd102, 8'd0);
		poke(8'(`UP_PROBE_ADDR), ~n);
		pokeInstr(8'd0, `UP_OP_LDA, 8'd100);
		pokeInstr(8'd2, `UP_OP_JZ, 8'd16);
		pokeInstr(8'd4, `UP_OP_SUB, 8'd101);
		pokeInstr(8'd6, `UP_OP_STA, 8'd100);
		pokeInstr(8'd8, `UP_OP_LDA, 8'd102);
		pokeInstr(8'd10, `UP_OP_ADD, 8'd101);
		pokeInstr(8'd12, `UP_OP_STA, 8'd102);
		pokeInstr(8'd14, `UP_OP_JMP, 8'd0);
		pokeInstr(8'd16, `UP_OP_LDA, 8'd102);
		pokeInstr(8'd18, `UP_OP_STA, 8'(`UP_PROBE_ADDR));
		pokeInstr(8'd20, `UP_OP_HLT, 8'd0);
		runToHalt();
		checkByte("probe", probe, n);
		endTest("jz countdown loop");

		randByte(a);
		randByte(b);
		poke(8'd110, a);
		poke(8'd111, b);
		poke(8'(`UP_PROBE_ADDR), ~(a + b));
		pokeInstr(8'd0, `UP_OP_LDA, 8'd110);
		pokeInstr(8'd2, 8'h00, 8'h55);
		pokeInstr(8'd4, 8'h0a, 8'h77);
		pokeInstr(8'd6, `UP_OP_ADD, 8'd111);
		pokeInstr(8'd8, 8'hff, 8'h12);
		pokeInstr(8'd10, `UP_OP_STA, 8'(`UP_PROBE_ADDR));
		pokeInstr(8'd12, `UP_OP_HLT, 8'd0);
		checkByte("acc", acc, n); // loop left its count in acc.
		runToHalt();
		checkByte("probe", probe, 8'((int'(a) + int'(b)) % 256));
		endTest("host writes and unknown opcodes");

		$display("%0d tests, %0d failed, %0d errors", testCount, failedTests, totalErrors());
		if (totalErrors() == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tests/upTop_props.sv
`include "up_consts.svh"

module upTopProps (
	input  logic clk,
	input  logic nRst,
	input  logic run,
	input  logic halted,
	input  logic [`UP_DATA_W-1:0] acc,
	input  logic [`UP_DATA_W-1:0] probe,
	input  logic [`UP_DATA_W-1:0] rdata,
	input  logic [`UP_DATA_W-1:0] aluResult,
	input  upPkg::decodedT dec,
	input  logic [`UP_DATA_W-1:0] opcode,
	input  logic coreWe,
	input  logic [`UP_DATA_W-1:0] coreAddr
);

	int unsigned failCount = 0;
	logic [1:0] phase; // 0 opcode, 1 address, 2 execute.

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			phase <= 2'd0;
		end else if (!run) begin
			phase <= 2'd0;
		end else if (!halted) begin
			phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
		end
	end

	aluAddWraps: assert property (@(posedge clk) disable iff (!nRst)
		dec.aluOp == upPkg::aluAdd |-> int'(aluResult) == (int'(acc) + int'(rdata)) % 256)
	else begin
		failCount++;
		$error("alu sum is not the sum modulo 256");
	end

	aluSubWraps: assert property (@(posedge clk) disable iff (!nRst)
		dec.aluOp == upPkg::aluSub
		|-> int'(aluResult) == (256 + int'(acc) - int'(rdata)) % 256)
	else begin
		failCount++;
		$error("alu difference is not the difference modulo 256");
	end

	writeOnlyInStore: assert property (@(posedge clk) disable iff (!nRst)
		coreWe |-> phase == 2'd2 && opcode == `UP_OP_STA)
	else begin
		failCount++;
		$error("core wrote memory outside the execute cycle of a store");
	end

	haltClearWhileStopped: assert property (@(posedge clk) disable iff (!nRst)
		!run |=> !halted)
	else begin
		failCount++;
		$error("halted is high while run is low");
	end

	probeFollowsStore: assert property (@(posedge clk) disable iff (!nRst)
		coreWe && coreAddr == 8'(`UP_PROBE_ADDR) |=> probe == $past(acc))
	else begin
		failCount++;
		$error("probe does not show the stored accumulator");
	end

endmodule

bind upTop upTopProps upTopProps_i (
	.clk(clk),
	.nRst(nRst),
	.run(run),
	.halted(halted),
	.acc(acc),
	.probe(probe),
	.rdata(rdata),
	.aluResult(aluResult),
	.dec(dec),
	.opcode(opcode),
	.coreWe(coreWe),
	.coreAddr(coreAddr)
);
